// ==== common/alu_defs.svh ====
// Build-time sizes for the ALU cluster, included by the package and by sized RTL blocks
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Lane count, also reorder depth, power of two >= 2
`define ALU_LANES 4

// Datapath width, divider and flags assume 32
`define ALU_XLEN 32

`endif

// ==== common/alu_pkg.sv ====
// Shared types of the ALU execute cluster, imported by the interface and every RTL block
`include "alu_defs.svh"

package alu_pkg;

  typedef logic [`ALU_XLEN-1:0]          word_t;     // Operand or result
  typedef logic [$clog2(`ALU_LANES)-1:0] tag_t;      // Issue sequence number
  typedef logic [$clog2(`ALU_LANES)-1:0] lane_sel_t; // Lane index

  // Opcode encodings of the ALU control field
  typedef enum logic [4:0] {
    OP_AND         = 5'd0,
    OP_OR          = 5'd1,
    OP_ADD         = 5'd2,
    OP_XOR         = 5'd3,
    OP_SUB         = 5'd4,
    OP_NOT         = 5'd5,
    OP_SLL         = 5'd6,
    OP_SRL         = 5'd7,
    OP_SRA         = 5'd8,
    OP_SLT         = 5'd9,
    OP_SLTU        = 5'd10,
    OP_MUL         = 5'd11, // Multiply group, not built
    OP_MULH        = 5'd12,
    OP_MULHSU      = 5'd13,
    OP_MULHU       = 5'd14,
    OP_DIV         = 5'd15, // Iterative divider from here
    OP_DIVU        = 5'd16,
    OP_REM         = 5'd17,
    OP_REMU        = 5'd18,
    OP_AMOSWAP     = 5'd19,
    OP_AMOMIN      = 5'd20,
    OP_AMOMAX      = 5'd21,
    OP_AMOMINU     = 5'd22,
    OP_AMOMAXU     = 5'd23,
    OP_SUBU_BORROW = 5'd24  // Unsigned sub with borrow out
  } alu_op_e;

  // Divider sequencing
  typedef enum logic [1:0] {
    IDLE = 2'd0, // Waiting for start
    RUN  = 2'd1, // One quotient bit per cycle
    FIX  = 2'd2  // Signs and special cases
  } div_state_e;

endpackage

// ==== common/lane_if.sv ====
// Per-lane bundle linking the dispatcher, one execute lane and the reorder collector
`timescale 1ns/1ps

interface lane_if;
  import alu_pkg::*;

  // Dispatcher to lane
  logic    issue;    // One-cycle strobe
  alu_op_e op;
  word_t   a;
  word_t   b;
  tag_t    tag;      // Sequence tag of the issued op

  // Lane to dispatcher and collector
  logic    busy;     // High from cycle after issue until done
  logic    done;     // One-cycle strobe
  word_t   result;
  logic    zero;
  logic    negative;
  logic    borrow;
  tag_t    done_tag; // Tag that goes with result

  modport dispatch (output issue, op, a, b, tag, input busy);
  modport lane     (input issue, op, a, b, tag,
                    output busy, done, result, zero, negative, borrow, done_tag);
  modport collect  (input done, result, zero, negative, borrow, done_tag);

endinterface

// ==== exec_lane/alu_core.sv ====
// Combinational ALU covering every non-divide opcode, used inside each execute lane
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_core (
  input  alu_pkg::alu_op_e op,
  input  alu_pkg::word_t   a,
  input  alu_pkg::word_t   b,
  output alu_pkg::word_t   result,
  output logic             zero,
  output logic             negative,
  output logic             borrow
);
  import alu_pkg::*;

  logic [`ALU_XLEN:0] sub_ext; // Unsigned diff plus borrow bit
  logic [4:0]         shamt;   // Low 5 bits of b only
  logic               lt_s;    // Signed a < b
  logic               lt_u;    // Unsigned a < b

  assign sub_ext = {1'b0, a} - {1'b0, b}; // Top bit set when a < b unsigned
  assign shamt   = b[4:0];
  assign lt_s    = $signed(a) < $signed(b);
  assign lt_u    = a < b;

  always_comb
  begin
    result = '0; // Default covers MUL group and unused codes
    borrow = 1'b0;
    case (op)
      OP_AND:
        result = a & b;
      OP_OR:
        result = a | b;
      OP_ADD:
        result = a + b;
      OP_XOR:
        result = a ^ b;
      OP_SUB:
        result = a - b;
      OP_NOT:
        result = ~a; // b ignored
      OP_SLL:
        result = a << shamt;
      OP_SRL:
        result = a >> shamt;
      OP_SRA:
        result = word_t'($signed(a) >>> shamt); // Sign fill
      OP_SLT:
        result = word_t'(lt_s);
      OP_SLTU:
        result = word_t'(lt_u);
      OP_AMOSWAP:
        result = b; // New memory value
      OP_AMOMIN:
        result = lt_s ? a : b;
      OP_AMOMAX:
        result = lt_s ? b : a; // Equal picks either, same value
      OP_AMOMINU:
        result = lt_u ? a : b;
      OP_AMOMAXU:
        result = lt_u ? b : a;
      OP_SUBU_BORROW:
      begin
        result = sub_ext[`ALU_XLEN-1:0];
        borrow = sub_ext[`ALU_XLEN]; // Only opcode with borrow
      end
      default:
        result = '0;
    endcase
  end

  // Flags follow the result
  assign zero     = (result == '0);
  assign negative = result[`ALU_XLEN-1];

endmodule

// ==== exec_lane/div_iter.sv ====
// Restoring divider for DIV/DIVU/REM/REMU, one quotient bit per cycle, started by a lane
`timescale 1ns/1ps
`include "alu_defs.svh"

module div_iter (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  logic           is_signed,
  input  logic           want_rem,
  input  alu_pkg::word_t a,
  input  alu_pkg::word_t b,
  output logic           done,
  output alu_pkg::word_t quotient_out
);
  import alu_pkg::*;

  localparam int    CNT_W    = $clog2(`ALU_XLEN);
  localparam word_t MOST_NEG = {1'b1, {(`ALU_XLEN-1){1'b0}}};

  div_state_e         state_q;
  logic [CNT_W-1:0]   cnt_q;      // Iteration count
  word_t              rem_q;      // Partial remainder
  word_t              quo_q;      // Dividend shifting out, quotient in
  word_t              divisor_q;  // Divisor magnitude
  word_t              dividend_q; // Original a, for divide by zero
  logic               quo_neg_q, rem_neg_q, want_rem_q, div_zero_q, ovf_q;
  word_t              mag_a, mag_b, quo_fix, rem_fix;
  logic [`ALU_XLEN:0] rem_shift, trial;

  assign mag_a     = (is_signed && a[`ALU_XLEN-1]) ? -a : a; // MOST_NEG maps to itself
  assign mag_b     = (is_signed && b[`ALU_XLEN-1]) ? -b : b;
  assign rem_shift = {rem_q, quo_q[`ALU_XLEN-1]};           // Bring down next bit
  assign trial     = rem_shift - {1'b0, divisor_q};         // Negative if it does not fit
  assign quo_fix   = quo_neg_q ? -quo_q : quo_q;
  assign rem_fix   = rem_neg_q ? -rem_q : rem_q;            // Remainder takes sign of a

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0; // Strobe
      case (state_q)
        IDLE:
          if (start)
          begin
            state_q <= RUN;
            cnt_q   <= '0;
          end
        RUN:
        begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(`ALU_XLEN-1))
            state_q <= FIX; // Last bit this cycle
        end
        FIX:
        begin
          state_q <= IDLE;
          done    <= 1'b1;
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && start)
    begin
      rem_q      <= '0;
      quo_q      <= mag_a;
      divisor_q  <= mag_b;
      dividend_q <= a;
      quo_neg_q  <= is_signed && (a[`ALU_XLEN-1] ^ b[`ALU_XLEN-1]);
      rem_neg_q  <= is_signed && a[`ALU_XLEN-1];
      want_rem_q <= want_rem;
      div_zero_q <= (b == '0);
      ovf_q      <= is_signed && (a == MOST_NEG) && (b == '1); // MOST_NEG / -1
    end
    else if (state_q == RUN)
    begin
      rem_q <= trial[`ALU_XLEN] ? rem_shift[`ALU_XLEN-1:0] : trial[`ALU_XLEN-1:0];
      quo_q <= {quo_q[`ALU_XLEN-2:0], ~trial[`ALU_XLEN]}; // 1 when divisor fit
    end
    if (state_q == FIX)
    begin
      if (div_zero_q)
        quotient_out <= want_rem_q ? dividend_q : '1;  // RISC-V divide by zero
      else if (ovf_q)
        quotient_out <= want_rem_q ? '0 : MOST_NEG;    // Signed overflow
      else
        quotient_out <= want_rem_q ? rem_fix : quo_fix;
    end
  end

endmodule

// ==== exec_lane/exec_lane.sv ====
// One execute lane: ALU result in one cycle or divide via div_iter, reported with its tag
`timescale 1ns/1ps

module exec_lane (
  input logic clk,
  input logic rst,
  lane_if.lane port
);
  import alu_pkg::*;

  word_t alu_res, alu_res_q, div_res;
  logic  alu_zero, alu_neg, alu_borrow;
  logic  alu_zero_q, alu_neg_q, alu_borrow_q;
  logic  alu_done_q, busy_q, is_div_q;
  logic  op_is_div, div_start, div_done;
  tag_t  tag_q;

  assign op_is_div = port.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign div_start = port.issue && op_is_div;

  // ALU sees the issue bus directly, result captured at the issue edge
  alu_core u_alu (.op(port.op), .a(port.a), .b(port.b), .result(alu_res),
                  .zero(alu_zero), .negative(alu_neg), .borrow(alu_borrow));

  div_iter u_div (.clk, .rst, .start(div_start),
                  .is_signed(port.op inside {OP_DIV, OP_REM}),
                  .want_rem(port.op inside {OP_REM, OP_REMU}),
                  .a(port.a), .b(port.b), .done(div_done), .quotient_out(div_res));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q     <= 1'b0;
      alu_done_q <= 1'b0;
    end
    else
    begin
      alu_done_q <= port.issue && !op_is_div; // Done one cycle after issue
      if (port.issue)
        busy_q <= 1'b1;
      else if (port.done)
        busy_q <= 1'b0; // Free again after the done cycle
    end
  end

  always_ff @(posedge clk)
  begin
    if (port.issue)
    begin
      tag_q        <= port.tag;
      is_div_q     <= op_is_div; // Selects which result is reported
      alu_res_q    <= alu_res;
      alu_zero_q   <= alu_zero;
      alu_neg_q    <= alu_neg;
      alu_borrow_q <= alu_borrow;
    end
  end

  assign port.busy     = busy_q;
  assign port.done     = alu_done_q | div_done;
  assign port.done_tag = tag_q;
  assign port.result   = is_div_q ? div_res : alu_res_q;
  assign port.zero     = is_div_q ? (div_res == '0) : alu_zero_q;
  assign port.negative = is_div_q ? div_res[$bits(word_t)-1] : alu_neg_q;
  assign port.borrow   = is_div_q ? 1'b0 : alu_borrow_q; // No borrow on divides

endmodule

// ==== hdl/alu_cluster_top.sv ====
// Top level of the ALU execute cluster: dispatcher, execute lanes and reorder collector
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_cluster_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,     // One op per cycle at most
  input  alu_pkg::alu_op_e in_op,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  output logic             full,         // Caller holds off while high
  output logic             out_valid,    // Strobe, results in issue order
  output alu_pkg::word_t   out_result,
  output logic             out_zero,
  output logic             out_negative,
  output logic             out_borrow
);

  logic retire; // Collector to dispatcher, one per released result

  lane_if lane_bus [`ALU_LANES] (); // One bundle per lane

  op_dispatch u_dispatch (
    .clk,
    .rst,
    .in_valid,
    .in_op,
    .in_a,
    .in_b,
    .retire,
    .full,
    .lanes    (lane_bus)
  );

  for (genvar i = 0; i < `ALU_LANES; i++)
  begin : g_lane
    exec_lane u_lane (.clk, .rst, .port(lane_bus[i]));
  end

  result_reorder u_reorder (
    .clk,
    .rst,
    .lanes        (lane_bus),
    .retire,
    .out_valid,
    .out_result,
    .out_zero,
    .out_negative,
    .out_borrow
  );

endmodule

// ==== hdl/op_dispatch.sv ====
// Issue stage: tags each incoming op, sends it to the lowest free lane and tracks full
`timescale 1ns/1ps
`include "alu_defs.svh"

module op_dispatch (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  alu_pkg::alu_op_e in_op,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  input  logic             retire,
  output logic             full,
  lane_if.dispatch         lanes [`ALU_LANES]
);
  import alu_pkg::*;

  localparam int CNT_W = $clog2(`ALU_LANES) + 1; // Counts 0..ALU_LANES

  logic [`ALU_LANES-1:0] busy_v, free_v, issue_q;
  logic [CNT_W-1:0]      count_q; // Outstanding ops, lanes plus buffer
  lane_sel_t             pick;
  logic                  any_free, accept;
  tag_t                  next_tag_q, tag_q;
  alu_op_e               op_q;
  word_t                 a_q, b_q;

  assign free_v = ~busy_v & ~issue_q;             // Lane strobed last cycle not busy yet
  assign full   = (count_q == CNT_W'(`ALU_LANES));
  assign accept = in_valid && !full && any_free;  // Input while full is dropped

  always_comb
  begin
    pick     = '0;
    any_free = 1'b0;
    for (int i = `ALU_LANES - 1; i >= 0; i--) // Lowest index wins
      if (free_v[i])
      begin
        pick     = lane_sel_t'(i);
        any_free = 1'b1;
      end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      issue_q    <= '0;
      count_q    <= '0;
      next_tag_q <= '0;
    end
    else
    begin
      issue_q <= '0;
      if (accept)
      begin
        issue_q[pick] <= 1'b1;
        next_tag_q    <= next_tag_q + 1'b1; // Wraps with buffer depth
      end
      case ({accept, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q  <= in_op;
      a_q   <= in_a;
      b_q   <= in_b;
      tag_q <= next_tag_q;
    end
  end

  // Payload broadcast, only the strobed lane takes it
  for (genvar i = 0; i < `ALU_LANES; i++)
  begin : g_lane_io
    assign busy_v[i]      = lanes[i].busy;
    assign lanes[i].issue = issue_q[i];
    assign lanes[i].op    = op_q;
    assign lanes[i].a     = a_q;
    assign lanes[i].b     = b_q;
    assign lanes[i].tag   = tag_q;
  end

endmodule

// ==== hdl/result_reorder.sv ====
// Reorder collector: buffers lane results by tag and releases them in issue order
`timescale 1ns/1ps
`include "alu_defs.svh"

module result_reorder (
  input  logic           clk,
  input  logic           rst,
  lane_if.collect        lanes [`ALU_LANES],
  output logic           retire,
  output logic           out_valid,
  output alu_pkg::word_t out_result,
  output logic           out_zero,
  output logic           out_negative,
  output logic           out_borrow
);
  import alu_pkg::*;

  logic [`ALU_LANES-1:0] done_v, zero_v, neg_v, borrow_v; // Gathered lane outputs
  word_t                 res_v [`ALU_LANES];
  tag_t                  tag_v [`ALU_LANES];
  logic [`ALU_LANES-1:0] slot_valid, slot_zero, slot_neg, slot_borrow;
  word_t                 slot_res [`ALU_LANES];
  tag_t                  head_q;  // Next tag due out
  logic                  rel_valid, rel_zero, rel_neg, rel_borrow;
  word_t                 rel_res;

  for (genvar i = 0; i < `ALU_LANES; i++)
  begin : g_lane_in
    assign done_v[i]   = lanes[i].done;
    assign res_v[i]    = lanes[i].result;
    assign zero_v[i]   = lanes[i].zero;
    assign neg_v[i]    = lanes[i].negative;
    assign borrow_v[i] = lanes[i].borrow;
    assign tag_v[i]    = lanes[i].done_tag;
  end

  // Head from buffer, else straight from a lane finishing it now
  always_comb
  begin
    rel_valid  = slot_valid[head_q];
    rel_res    = slot_res[head_q];
    rel_zero   = slot_zero[head_q];
    rel_neg    = slot_neg[head_q];
    rel_borrow = slot_borrow[head_q];
    if (!slot_valid[head_q])
      for (int i = 0; i < `ALU_LANES; i++)
        if (done_v[i] && tag_v[i] == head_q)
        begin
          rel_valid  = 1'b1;
          rel_res    = res_v[i];
          rel_zero   = zero_v[i];
          rel_neg    = neg_v[i];
          rel_borrow = borrow_v[i];
        end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slot_valid <= '0;
      head_q     <= '0;
      out_valid  <= 1'b0;
      retire     <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < `ALU_LANES; i++)
        if (done_v[i])
          slot_valid[tag_v[i]] <= 1'b1; // Tags outstanding are unique
      if (rel_valid)
      begin
        slot_valid[head_q] <= 1'b0;     // Overrides a bypassed write
        head_q             <= head_q + 1'b1;
      end
      out_valid <= rel_valid;
      retire    <= rel_valid;           // Frees one count in dispatch
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `ALU_LANES; i++)
      if (done_v[i])
      begin
        slot_res[tag_v[i]]    <= res_v[i];
        slot_zero[tag_v[i]]   <= zero_v[i];
        slot_neg[tag_v[i]]    <= neg_v[i];
        slot_borrow[tag_v[i]] <= borrow_v[i];
      end
    if (rel_valid)
    begin
      out_result   <= rel_res;
      out_zero     <= rel_zero;
      out_negative <= rel_neg;
      out_borrow   <= rel_borrow;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU cluster testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module alu_cluster_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Valu_cluster_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tests/alu_cluster_tb.sv ====
// Testbench that drives the ALU cluster from the stim file and checks results in issue order
`timescale 1ns/1ps

module alu_cluster_tb;
  import alu_pkg::*;

  logic    clk, rst, in_valid;
  alu_op_e in_op;
  word_t   in_a, in_b;
  logic    full, out_valid, out_zero, out_negative, out_borrow;
  word_t   out_result;

  logic [4:0] stim_op [$];  // Columns of the stim file
  word_t      stim_a [$], stim_b [$], stim_res [$];
  logic       stim_z [$], stim_n [$], stim_bo [$];
  int         pending [$];  // Stim indices issued, oldest first
  int         num_ops, cycle_count, timeout_limit, gap;
  bit         full_seen;    // Set once back-pressure was observed

  alu_cluster_top DUT (.clk, .rst, .in_valid, .in_op, .in_a, .in_b, .full, .out_valid,
                       .out_result, .out_zero, .out_negative, .out_borrow);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic compare_value(string name, word_t expected, word_t actual);
    assert (actual === expected)
    else stop_on_error($sformatf("Mismatch at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual));
  endtask

  task automatic load_stimulus();
    int         fd, n;
    string      line;
    logic [4:0] op_v;
    word_t      a_v, b_v, r_v;
    logic       z_v, n_v, bo_v;
    fd = $fopen("tests/alu_stim.txt", "r");
    if (fd == 0)
      stop_on_error("Could not open the stimulus file tests/alu_stim.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") // Blank or column note
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h", op_v, a_v, b_v, r_v, z_v, n_v, bo_v);
      if (n != 7)
        stop_on_error($sformatf("Stimulus line has %0d fields instead of 7", n));
      stim_op.push_back(op_v);
      stim_a.push_back(a_v);
      stim_b.push_back(b_v);
      stim_res.push_back(r_v);
      stim_z.push_back(z_v);
      stim_n.push_back(n_v);
      stim_bo.push_back(bo_v);
    end
    $fclose(fd);
    num_ops = stim_op.size();
  endtask

  task automatic check_result();
    int idx;
    assert (pending.size() != 0)
    else stop_on_error("out_valid pulsed with no operation outstanding");
    idx = pending.pop_front(); // Issue order is the expected order
    compare_value("out_result", stim_res[idx], out_result);
    compare_value("out_zero", word_t'(stim_z[idx]), word_t'(out_zero));
    compare_value("out_negative", word_t'(stim_n[idx]), word_t'(out_negative));
    compare_value("out_borrow", word_t'(stim_bo[idx]), word_t'(out_borrow));
  endtask

  // Registered outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst && full === 1'b1)
      full_seen = 1'b1;
    if (!rst && out_valid === 1'b1)
      check_result();
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
      stop_on_error("Timeout: results stopped arriving before all operations retired");
  end

  initial
  begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_op       = OP_AND;
    in_a        = '0;
    in_b        = '0;
    cycle_count = 0;
    full_seen   = 1'b0;
    void'($urandom(32'hf88d)); // Single seed for the gaps
    load_stimulus();
    timeout_limit = num_ops * 40 + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < num_ops; i++)
    begin
      gap = $urandom_range(0, 3);
      repeat (gap) @(negedge clk);    // Idle cycles with in_valid low
      while (full) @(negedge clk);    // Hold off while no slot
      in_valid = 1'b1;
      in_op    = alu_op_e'(stim_op[i]);
      in_a     = stim_a[i];
      in_b     = stim_b[i];
      pending.push_back(i);
      @(negedge clk);
      in_valid = 1'b0;
    end
    assert (full_seen)
    else stop_on_error("full never rose during the run of back-to-back divides");
    while (pending.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);        // Catch stray out_valid pulses
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== tests/alu_stim.txt ====
# Columns, all hex: op a b expected_result zero negative borrow
# One operation per line, issued in file order
00 f0f0f0f0 ff00ff00 f000f000 0 1 0
01 f0f0f0f0 0f0f0f0f ffffffff 0 1 0
02 7fffffff 00000001 80000000 0 1 0
02 ffffffff 00000001 00000000 1 0 0
03 12345678 12345678 00000000 1 0 0
04 00000005 00000007 fffffffe 0 1 0
05 0000ffff 12345678 ffff0000 0 1 0
06 00000001 0000001f 80000000 0 1 0
06 00000003 00000024 00000030 0 0 0
07 80000000 0000001f 00000001 0 0 0
08 80000010 00000004 f8000001 0 1 0
09 ffffffff 00000001 00000001 0 0 0
0a ffffffff 00000001 00000000 1 0 0
0b 00000003 00000004 00000000 1 0 0
13 11111111 22222222 22222222 0 0 0
14 ffffff00 00000010 ffffff00 0 1 0
15 ffffff00 00000010 00000010 0 0 0
16 ffffff00 00000010 00000010 0 0 0
17 ffffff00 00000010 ffffff00 0 1 0
18 00000003 00000005 fffffffe 0 1 1
18 00000009 00000004 00000005 0 0 0
18 00000007 00000007 00000000 1 0 0
1f 12345678 9abcdef0 00000000 1 0 0
0f fffffff9 00000002 fffffffd 0 1 0
11 fffffff9 00000002 ffffffff 0 1 0
10 ffffffff 00000010 0fffffff 0 0 0
12 00000064 00000007 00000002 0 0 0
0f 80000000 ffffffff 80000000 0 1 0
11 80000000 ffffffff 00000000 1 0 0
0f 00001234 00000000 ffffffff 0 1 0
12 00001234 00000000 00001234 0 0 0
02 00000001 00000002 00000003 0 0 0
10 00000064 0000000a 0000000a 0 0 0
04 00000000 00000001 ffffffff 0 1 0

// ==== vlog.f ====
+incdir+common
common/alu_pkg.sv
common/lane_if.sv
exec_lane/alu_core.sv
exec_lane/div_iter.sv
exec_lane/exec_lane.sv
hdl/op_dispatch.sv
hdl/result_reorder.sv
hdl/alu_cluster_top.sv
tests/alu_cluster_tb.sv
